/* logic/decode_pkg.sv */
// Shared types for the RV32I decode stage
// Data, register index, register mask and tag widths
// Execution unit, operation, format and issue state enums
// RV32I major opcodes used by the decoder
`default_nettype none

package decode_pkg;

    typedef logic [31:0] word_t;                // Instruction, operand, PC, register data
    typedef logic [4:0]  reg_idx_t;             // Register index
    typedef logic [31:0] reg_mask_t;            // One-hot register set, bit 0 is pending store
    typedef logic [3:0]  tag_t;                 // Instruction tag

    typedef enum logic [2:0] {
        XU_ADDER,
        XU_LOGICAL,
        XU_SHIFTER,
        XU_BRANCH,
        XU_MEMORY,
        XU_BYPASS,
        XU_ILLEGAL
    } xu_t;

    // Operation within a unit, meaning depends on the unit
    typedef enum logic [2:0] {
        OP0,
        OP1,
        OP2,
        OP3,
        OP4,
        OP5,
        OP6,
        OP7
    } op_t;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } fmt_t;

    typedef enum logic {
        EMPTY,                                  // Output register free
        HELD                                    // Output register holds an op
    } issue_state_t;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA variants

endpackage

`default_nettype wire

/* logic/instr_decoder.sv */
// Instruction decoder for the RV32I decode stage
// Unit and operation classification, format and immediate
// Operand selection and the registered operand outputs
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire logic              clk,
    input  wire logic              reset,
    input  decode_pkg::word_t      instruction,
    input  decode_pkg::word_t      npc,
    input  decode_pkg::tag_t       tag_in,
    input  decode_pkg::word_t      data_a,      // rs1 data from bank
    input  decode_pkg::word_t      data_b,      // rs2 data from bank
    input  wire logic              load_en,     // Accept into output register
    output decode_pkg::reg_idx_t   rs1,
    output decode_pkg::reg_idx_t   rs2,
    output logic                   uses_rs2,
    output logic                   is_load,
    output decode_pkg::reg_mask_t  dest_mask,
    output decode_pkg::word_t      op_a,
    output decode_pkg::word_t      op_b,
    output decode_pkg::word_t      op_c,
    output decode_pkg::word_t      npc_out,
    output decode_pkg::op_t        op_code,
    output decode_pkg::xu_t        xu_sel,
    output decode_pkg::tag_t       tag_out
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] sel;                            // {unit, operation}
    decode_pkg::xu_t   xu;
    decode_pkg::op_t   op;
    decode_pkg::fmt_t  fmt;
    decode_pkg::word_t imm;
    logic legal, uses_rs1, writes_rd, is_store;

    function automatic logic [5:0] code(input decode_pkg::xu_t u, input decode_pkg::op_t o);
        return {u, o};
    endfunction

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb begin
        sel = code(decode_pkg::XU_ILLEGAL, decode_pkg::OP0);    // Unrecognized word
        fmt = decode_pkg::FMT_R;
        if (instruction == '0 || instruction == 32'h0000_0013) begin
            sel = code(decode_pkg::XU_BYPASS, decode_pkg::OP0);  // NOP forms
        end else begin
            case (opcode)
                decode_pkg::OPC_LUI: begin
                    fmt = decode_pkg::FMT_U;
                    sel = code(decode_pkg::XU_BYPASS, decode_pkg::OP1);
                end
                decode_pkg::OPC_AUIPC: begin
                    fmt = decode_pkg::FMT_U;
                    sel = code(decode_pkg::XU_ADDER, decode_pkg::OP0);
                end
                decode_pkg::OPC_JAL: begin
                    fmt = decode_pkg::FMT_J;
                    sel = code(decode_pkg::XU_BRANCH, decode_pkg::OP6);
                end
                decode_pkg::OPC_JALR: begin
                    fmt = decode_pkg::FMT_I;
                    if (funct3 == 3'b000)
                        sel = code(decode_pkg::XU_BRANCH, decode_pkg::OP7);
                end
                decode_pkg::OPC_BRANCH: begin
                    fmt = decode_pkg::FMT_B;
                    case (funct3)
                        3'b000:  sel = code(decode_pkg::XU_BRANCH, decode_pkg::OP0);  // BEQ
                        3'b001:  sel = code(decode_pkg::XU_BRANCH, decode_pkg::OP1);  // BNE
                        3'b100:  sel = code(decode_pkg::XU_BRANCH, decode_pkg::OP2);  // BLT
                        3'b101:  sel = code(decode_pkg::XU_BRANCH, decode_pkg::OP4);  // BGE
                        3'b110:  sel = code(decode_pkg::XU_BRANCH, decode_pkg::OP3);  // BLTU
                        3'b111:  sel = code(decode_pkg::XU_BRANCH, decode_pkg::OP5);  // BGEU
                        default: ;
                    endcase
                end
                decode_pkg::OPC_LOAD: begin
                    fmt = decode_pkg::FMT_I;
                    case (funct3)
                        3'b000:  sel = code(decode_pkg::XU_MEMORY, decode_pkg::OP0);  // LB
                        3'b001:  sel = code(decode_pkg::XU_MEMORY, decode_pkg::OP2);  // LH
                        3'b010:  sel = code(decode_pkg::XU_MEMORY, decode_pkg::OP4);  // LW
                        3'b100:  sel = code(decode_pkg::XU_MEMORY, decode_pkg::OP1);  // LBU
                        3'b101:  sel = code(decode_pkg::XU_MEMORY, decode_pkg::OP3);  // LHU
                        default: ;
                    endcase
                end
                decode_pkg::OPC_STORE: begin
                    fmt = decode_pkg::FMT_S;
                    case (funct3)
                        3'b000:  sel = code(decode_pkg::XU_MEMORY, decode_pkg::OP7);  // SB
                        3'b001:  sel = code(decode_pkg::XU_MEMORY, decode_pkg::OP6);  // SH
                        3'b010:  sel = code(decode_pkg::XU_MEMORY, decode_pkg::OP5);  // SW
                        default: ;
                    endcase
                end
                decode_pkg::OPC_OP_IMM, decode_pkg::OPC_OP: begin
                    fmt = (opcode == decode_pkg::OPC_OP) ? decode_pkg::FMT_R : decode_pkg::FMT_I;
                    // Shifts always check funct7, other ALU ops only in R format
                    if (funct7 == decode_pkg::F7_BASE || (fmt == decode_pkg::FMT_I &&
                            funct3 != 3'b001 && funct3 != 3'b101)) begin
                        case (funct3)
                            3'b000:  sel = code(decode_pkg::XU_ADDER, decode_pkg::OP0);
                            3'b001:  sel = code(decode_pkg::XU_SHIFTER, decode_pkg::OP0);
                            3'b010:  sel = code(decode_pkg::XU_ADDER, decode_pkg::OP3);
                            3'b011:  sel = code(decode_pkg::XU_ADDER, decode_pkg::OP2);
                            3'b100:  sel = code(decode_pkg::XU_LOGICAL, decode_pkg::OP0);
                            3'b101:  sel = code(decode_pkg::XU_SHIFTER, decode_pkg::OP1);
                            3'b110:  sel = code(decode_pkg::XU_LOGICAL, decode_pkg::OP1);
                            default: sel = code(decode_pkg::XU_LOGICAL, decode_pkg::OP2);
                        endcase
                    end else if (funct7 == decode_pkg::F7_ALT) begin
                        if (funct3 == 3'b101)
                            sel = code(decode_pkg::XU_SHIFTER, decode_pkg::OP2);  // SRA, SRAI
                        else if (funct3 == 3'b000 && fmt == decode_pkg::FMT_R)
                            sel = code(decode_pkg::XU_ADDER, decode_pkg::OP1);    // SUB
                    end
                end
                default: ;
            endcase
        end
    end

    assign xu = decode_pkg::xu_t'(sel[5:3]);
    assign op = decode_pkg::op_t'(sel[2:0]);

    always_comb begin
        case (fmt)                              // Sign-extended immediate by format
            decode_pkg::FMT_I: imm = {{20{instruction[31]}}, instruction[31:20]};
            decode_pkg::FMT_S: imm = {{20{instruction[31]}}, funct7, instruction[11:7]};
            decode_pkg::FMT_B: imm = {{20{instruction[31]}}, instruction[7],
                                      instruction[30:25], instruction[11:8], 1'b0};
            decode_pkg::FMT_U: imm = {instruction[31:12], 12'b0};
            decode_pkg::FMT_J: imm = {{12{instruction[31]}}, instruction[19:12],
                                      instruction[20], instruction[30:21], 1'b0};
            default:           imm = '0;
        endcase
    end

    // Register usage for hazard check and bank addressing
    assign legal     = (xu != decode_pkg::XU_ILLEGAL);
    assign uses_rs1  = legal && fmt != decode_pkg::FMT_U && fmt != decode_pkg::FMT_J;
    assign uses_rs2  = legal && (fmt == decode_pkg::FMT_R || fmt == decode_pkg::FMT_S ||
                                 fmt == decode_pkg::FMT_B);
    assign rs1       = uses_rs1 ? instruction[19:15] : '0;
    assign rs2       = instruction[24:20];
    assign is_load   = legal && opcode == decode_pkg::OPC_LOAD;
    assign is_store  = legal && opcode == decode_pkg::OPC_STORE;
    assign writes_rd = legal && fmt != decode_pkg::FMT_S && fmt != decode_pkg::FMT_B &&
                       instruction[11:7] != '0;

    always_comb begin
        dest_mask = '0;
        if (writes_rd)
            dest_mask[instruction[11:7]] = 1'b1;
        dest_mask[0] = is_store;                // Memory write in flight
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            op_a    <= '0;
            op_b    <= '0;
            op_c    <= '0;
            npc_out <= '0;
            op_code <= decode_pkg::OP0;
            xu_sel  <= decode_pkg::XU_BYPASS;
            tag_out <= '0;
        end else if (load_en) begin
            op_a    <= (fmt == decode_pkg::FMT_U || fmt == decode_pkg::FMT_J) ? npc : data_a;
            op_b    <= (fmt == decode_pkg::FMT_R || fmt == decode_pkg::FMT_B) ? data_b : imm;
            op_c    <= (fmt == decode_pkg::FMT_S) ? data_b : imm;
            npc_out <= npc;
            op_code <= op;
            xu_sel  <= xu;
            tag_out <= tag_in;
        end
    end

endmodule

`default_nettype wire

/* logic/register_bank.sv */
// Register bank, 31 writable registers plus constant x0
// Two combinational read ports, write-first on collision
`timescale 1ns/1ps
`default_nettype none

module register_bank (
    input  wire logic             clk,
    input  wire logic             reset,
    input  decode_pkg::reg_idx_t  rd_addr_a,
    input  decode_pkg::reg_idx_t  rd_addr_b,
    output decode_pkg::word_t     rd_data_a,
    output decode_pkg::word_t     rd_data_b,
    input  wire logic             wr_en,
    input  decode_pkg::reg_idx_t  wr_addr,
    input  decode_pkg::word_t     wr_data
);

    decode_pkg::word_t regs [1:31];
    logic wr_live;

    assign wr_live = wr_en && wr_addr != '0;    // x0 writes dropped

    function automatic decode_pkg::word_t read_port(input decode_pkg::reg_idx_t addr);
        if (addr == '0)
            return '0;
        if (wr_live && addr == wr_addr)         // Bypass the write in progress
            return wr_data;
        return regs[addr];
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* logic/write_lock_queue.sv */
// Pending-write queue, one one-hot mask per cycle of execute latency
// Locked register set and write-back destination from the head
`timescale 1ns/1ps
`default_nettype none

module write_lock_queue #(
    parameter int DEPTH = 2                     // Cycles from dispatch to write-back
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  decode_pkg::reg_mask_t  push_mask,   // Zero when nothing dispatched
    output decode_pkg::reg_mask_t  locked,
    output decode_pkg::reg_idx_t   wb_rd,
    output logic                   wb_pending
);

    decode_pkg::reg_mask_t entry [DEPTH];
    decode_pkg::reg_mask_t head;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < DEPTH; i++)
                entry[i] <= '0;
        end else begin
            entry[0] <= push_mask;
            for (int i = 1; i < DEPTH; i++)
                entry[i] <= entry[i-1];         // Advance one slot per cycle
        end
    end

    assign head       = entry[DEPTH-1];
    assign wb_pending = |head;

    always_comb begin
        locked = '0;
        for (int i = 0; i < DEPTH; i++)
            locked = locked | entry[i];
        wb_rd = '0;                             // Store slot maps to x0
        for (int i = 1; i < 32; i++)
            if (head[i])
                wb_rd = decode_pkg::reg_idx_t'(i);
    end

endmodule

`default_nettype wire

/* logic/issue_control.sv */
// Issue control for the decode output register
// EMPTY/HELD FSM, hazard test, fetch and execute handshakes
`timescale 1ns/1ps
`default_nettype none

module issue_control (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              in_valid,
    output logic                   in_ready,
    output logic                   op_valid,
    input  wire logic              op_ready,
    input  decode_pkg::reg_idx_t   rs1,
    input  decode_pkg::reg_idx_t   rs2,
    input  wire logic              uses_rs2,
    input  wire logic              is_load,
    input  decode_pkg::reg_mask_t  dest_mask,
    input  decode_pkg::reg_mask_t  locked,
    output logic                   load_en,
    output decode_pkg::reg_mask_t  push_mask
);

    decode_pkg::issue_state_t state;
    decode_pkg::reg_mask_t    held_mask;        // Destination of the held op
    decode_pkg::reg_mask_t    lock_all;
    logic dispatch, room, hazard;

    assign op_valid = (state == decode_pkg::HELD);
    assign dispatch = op_valid && op_ready;
    assign room     = !op_valid || op_ready;    // Output register free next edge

    // Held op still counts as in flight
    // Bit 0 marks a pending store and is never read as x0
    assign lock_all = locked | held_mask;
    assign hazard   = (rs1 != '0 && lock_all[rs1]) ||
                      (uses_rs2 && rs2 != '0 && lock_all[rs2]) ||
                      (is_load && lock_all[0]);

    assign in_ready  = reset && room && !hazard;    // Refused while reset is held
    assign load_en   = in_valid && in_ready;
    assign push_mask = dispatch ? held_mask : '0;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= decode_pkg::EMPTY;
            held_mask <= '0;
        end else if (load_en) begin
            state     <= decode_pkg::HELD;
            held_mask <= dest_mask;
        end else if (dispatch) begin
            state     <= decode_pkg::EMPTY;
            held_mask <= '0;
        end
    end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// Decode stage top level
// Decoder, register bank, write lock queue and issue control
// Write-back from execute enters the bank at the queue head
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int DEPTH = 2                     // Execute latency, 1 to 8
) (
    input  wire logic             clk,
    input  wire logic             reset,
    // Fetch side
    input  wire logic             in_valid,
    output logic                  in_ready,
    input  decode_pkg::word_t     instruction,
    input  decode_pkg::word_t     npc,
    input  decode_pkg::tag_t      tag_in,
    // Execute side
    output logic                  op_valid,
    input  wire logic             op_ready,
    output decode_pkg::word_t     op_a,
    output decode_pkg::word_t     op_b,
    output decode_pkg::word_t     op_c,
    output decode_pkg::word_t     npc_out,
    output decode_pkg::op_t       op_code,
    output decode_pkg::xu_t       xu_sel,
    output decode_pkg::tag_t      tag_out,
    // Write-back
    output decode_pkg::reg_idx_t  wb_rd,
    output logic                  wb_pending,
    input  decode_pkg::word_t     wb_data
);

    decode_pkg::reg_idx_t  rs1, rs2;
    decode_pkg::word_t     data_a, data_b;
    decode_pkg::reg_mask_t dest_mask, locked, push_mask;
    logic uses_rs2, is_load, load_en;

    instr_decoder decoder_i (
        .clk, .reset,
        .instruction, .npc, .tag_in,
        .data_a, .data_b, .load_en,
        .rs1, .rs2, .uses_rs2, .is_load, .dest_mask,
        .op_a, .op_b, .op_c, .npc_out, .op_code, .xu_sel, .tag_out
    );

    register_bank bank_i (
        .clk, .reset,
        .rd_addr_a (rs1),
        .rd_addr_b (rs2),
        .rd_data_a (data_a),
        .rd_data_b (data_b),
        .wr_en     (wb_pending),                // x0 and store slots ignored in bank
        .wr_addr   (wb_rd),
        .wr_data   (wb_data)
    );

    write_lock_queue #(.DEPTH(DEPTH)) queue_i (
        .clk, .reset,
        .push_mask, .locked, .wb_rd, .wb_pending
    );

    issue_control control_i (
        .clk, .reset,
        .in_valid, .in_ready, .op_valid, .op_ready,
        .rs1, .rs2, .uses_rs2, .is_load, .dest_mask,
        .locked, .load_en, .push_mask
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
// Clock and reset generator for the decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 4,             // ns
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b0;                           // Active low, held from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b1;                        // Released just after an edge
    end

endmodule

`default_nettype wire

/* sim/decode_stage_props.sv */
// Assertions bound to the decode stage top level
// Reset values, op stability under back-pressure, write-back versus operand read
`timescale 1ns/1ps
`default_nettype none

module decode_stage_props (
    input wire logic             clk,
    input wire logic             reset,
    input wire logic             in_valid,
    input wire logic             in_ready,
    input wire logic             op_valid,
    input wire logic             op_ready,
    input decode_pkg::word_t     op_a,
    input decode_pkg::word_t     op_b,
    input decode_pkg::word_t     op_c,
    input decode_pkg::word_t     npc_out,
    input decode_pkg::op_t       op_code,
    input decode_pkg::xu_t       xu_sel,
    input decode_pkg::tag_t      tag_out,
    input decode_pkg::reg_idx_t  wb_rd,
    input wire logic             wb_pending,
    input decode_pkg::reg_idx_t  rs1,
    input decode_pkg::reg_idx_t  rs2,
    input wire logic             uses_rs2
);

    int fail_count = 0;                         // Failed assertion attempts

    // Outputs quiet while reset is held
    reset_quiet: assert property (@(posedge clk) !reset |-> !op_valid && !wb_pending)
        else begin
            $error("op_valid or wb_pending high during reset");
            fail_count++;
        end

    // Stalled op keeps every field
    stall_stable: assert property (@(posedge clk) disable iff (!reset)
        op_valid && !op_ready |=> op_valid &&
        $stable({op_a, op_b, op_c, npc_out, op_code, xu_sel, tag_out}))
        else begin
            $error("op outputs changed while stalled");
            fail_count++;
        end

    // Register still locked in its write-back cycle
    wb_no_read: assert property (@(posedge clk) disable iff (!reset)
        wb_pending && wb_rd != '0 && in_valid && in_ready |->
        rs1 != wb_rd && (!uses_rs2 || rs2 != wb_rd))
        else begin
            $error("operand accepted from register in write-back");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_props props_i (.*);

`default_nettype wire

/* sim/decode_stage_tb.sv */
// Directed testbench for the decode stage
// Execute model with write-back, reference register file, checker, watchdog
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    localparam int DEPTH   = 2;
    localparam int CYCLE   = 4;
    localparam int N_INSTR = 90;                // Upper bound of issued instructions

    logic clk, reset, in_valid, in_ready, op_valid, op_ready, wb_pending;
    decode_pkg::word_t instruction, npc, op_a, op_b, op_c, npc_out, wb_data;
    decode_pkg::tag_t tag_in, tag_out;
    decode_pkg::op_t op_code;
    decode_pkg::xu_t xu_sel;
    decode_pkg::reg_idx_t wb_rd;

    int errors = 0, checks = 0, test_start = 0;
    decode_pkg::word_t ref_regs [32];           // Reference register file
    decode_pkg::word_t wb_val [16];             // Result chosen per tag
    decode_pkg::word_t pipe_val [DEPTH];        // Execute model pipeline
    int pipe_dest [DEPTH];                      // -1 none, 0 store, else rd
    int acc_dest [$];
    decode_pkg::tag_t acc_tag [$];
    logic disp_now = 1'b0;
    decode_pkg::word_t disp_value;
    int disp_dest;
    time last_wb_time [32];
    time accept_time;
    logic [31:0] lcg_state = 32'h4301;

    tb_clock #(.PERIOD(CYCLE), .RESET_CYCLES(5)) clock_i (.clk, .reset);

    decode_stage #(.DEPTH(DEPTH)) decode_stage_i (.*);

    assign wb_data = pipe_val[DEPTH-1];

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic end_test(input string name);
        $display("%-14s %0d error(s)", name, errors - test_start);
        test_start = errors;
    endtask

    // Destination slot of an instruction by opcode
    function automatic int dest_of(input decode_pkg::word_t instr);
        case (instr[6:0])
            decode_pkg::OPC_STORE:  return 0;
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC, decode_pkg::OPC_JAL,
            decode_pkg::OPC_JALR, decode_pkg::OPC_LOAD, decode_pkg::OPC_OP_IMM,
            decode_pkg::OPC_OP:     return (instr[11:7] != 0) ? int'(instr[11:7]) : -1;
            default:                return -1;
        endcase
    endfunction

    // Expected operands by format rule
    // Returns 0 when no operand rule applies
    function automatic bit expect_ops(input decode_pkg::word_t i, input decode_pkg::word_t pc,
                                      output decode_pkg::word_t ea, eb, ec);
        decode_pkg::word_t r1, r2, imm;
        r1 = ref_regs[i[19:15]];
        r2 = ref_regs[i[24:20]];
        ea = r1;
        case (i[6:0])
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                imm = {i[31:12], 12'b0};
                ea = pc; eb = imm; ec = imm;
            end
            decode_pkg::OPC_JAL: begin
                imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
                ea = pc; eb = imm; ec = imm;
            end
            decode_pkg::OPC_JALR, decode_pkg::OPC_LOAD, decode_pkg::OPC_OP_IMM: begin
                imm = {{20{i[31]}}, i[31:20]};
                eb = imm; ec = imm;
            end
            decode_pkg::OPC_BRANCH: begin
                eb = r2; ec = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            end
            decode_pkg::OPC_STORE: begin
                eb = {{20{i[31]}}, i[31:25], i[11:7]}; ec = r2;
            end
            decode_pkg::OPC_OP: begin
                eb = r2; ec = '0;
            end
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    // Execute model samples mid-cycle where DUT outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            if (pipe_dest[DEPTH-1] >= 0) begin
                check("wb_pending", 1, wb_pending);
                check("wb_rd", pipe_dest[DEPTH-1], wb_rd);
                if (pipe_dest[DEPTH-1] != 0)
                    ref_regs[pipe_dest[DEPTH-1]] = pipe_val[DEPTH-1];
                last_wb_time[pipe_dest[DEPTH-1]] = $time;
            end else begin
                check("wb_pending", 0, wb_pending);
            end
            disp_now = op_valid && op_ready;
            if (disp_now && acc_tag.size() == 0) begin
                note_error("dispatch without an accepted instruction");
                disp_now = 1'b0;
            end else if (disp_now) begin
                check("tag_out", acc_tag[0], tag_out);  // Dispatch order
                disp_value = wb_val[acc_tag.pop_front()];
                disp_dest  = acc_dest.pop_front();
            end
        end
    end

    always @(posedge clk) begin
        #1;
        for (int i = DEPTH - 1; i > 0; i--) begin
            pipe_val[i]  = pipe_val[i-1];
            pipe_dest[i] = pipe_dest[i-1];
        end
        pipe_val[0]  = disp_now ? disp_value : '0;
        pipe_dest[0] = disp_now ? disp_dest : -1;
        disp_now = 1'b0;
    end

    // Offer until accepted, then check the registered op
    task automatic issue(input decode_pkg::word_t instr, input decode_pkg::word_t pc,
                         input decode_pkg::tag_t tag, output int waits);
        decode_pkg::word_t ea, eb, ec;
        waits = 0;
        in_valid = 1'b1;
        instruction = instr;
        npc = pc;
        tag_in = tag;
        @(negedge clk);
        while (!in_ready) begin
            waits++;
            @(negedge clk);
        end
        @(posedge clk);
        accept_time = $time;
        acc_tag.push_back(tag);
        acc_dest.push_back(dest_of(instr));
        #1;
        in_valid = 1'b0;
        instruction = '0;
        check("op_valid", 1, op_valid);
        check("tag_out", tag, tag_out);
        check("npc_out", pc, npc_out);
        if (expect_ops(instr, pc, ea, eb, ec)) begin
            check("op_a", ea, op_a);
            check("op_b", eb, op_b);
            check("op_c", ec, op_c);
        end
    endtask

    task automatic drain();
        repeat (DEPTH + 3) @(posedge clk);
        #1;
    endtask

    task automatic reset_values();
        int w;
        check("in_ready", 1, in_ready);
        check("op_valid", 0, op_valid);
        check("wb_pending", 0, wb_pending);
        issue(32'h006280B3, 32'h100, 4'd0, w);  // ADD x1, x5, x6
        check("op_a", 0, op_a);
        check("op_b", 0, op_b);
        drain();
        end_test("reset");
    endtask

    task automatic decode_table();
        decode_pkg::word_t instr [11] = '{32'h123452B7, 32'h00001217, 32'h008000EF,
            32'h000180E7, 32'h00518863, 32'hFFC1A303, 32'h0051A423, 32'hFFF18393,
            32'h4051D413, 32'h405184B3, 32'hFFFFFFFF};
        decode_pkg::xu_t xu [11] = '{decode_pkg::XU_BYPASS, decode_pkg::XU_ADDER,
            decode_pkg::XU_BRANCH, decode_pkg::XU_BRANCH, decode_pkg::XU_BRANCH,
            decode_pkg::XU_MEMORY, decode_pkg::XU_MEMORY, decode_pkg::XU_ADDER,
            decode_pkg::XU_SHIFTER, decode_pkg::XU_ADDER, decode_pkg::XU_ILLEGAL};
        int op [11] = '{1, 0, 6, 7, 0, 4, 5, 0, 2, 1, 0};
        int w;
        wb_val[1] = lcg_next();
        wb_val[2] = lcg_next();
        issue(32'h00000193, 32'h200, 4'd1, w);  // ADDI x3 preload
        issue(32'h00000293, 32'h204, 4'd2, w);  // ADDI x5 preload
        drain();
        for (int k = 0; k < 11; k++) begin
            wb_val[(k + 3) % 16] = lcg_next();
            issue(instr[k], 32'h1000 + 4 * k, decode_pkg::tag_t'(k + 3), w);
            check("xu_sel", xu[k], xu_sel);
            check("op_code", op[k], op_code);
        end
        drain();
        end_test("decode table");
    endtask

    task automatic read_after_write();
        int w;
        last_wb_time[7] = 0;
        wb_val[6] = 32'hCAFE_0007;
        issue(32'h00000393, 32'h300, 4'd6, w);  // ADDI x7, x0, 0
        issue(32'h00038533, 32'h304, 4'd7, w);  // ADD x10, x7, x0
        if (last_wb_time[7] == 0 || accept_time <= last_wb_time[7])
            note_error("reader of x7 accepted before its write-back");
        check("op_a", 32'hCAFE_0007, op_a);
        drain();
        end_test("read after write");
    endtask

    task automatic back_pressure();
        int w;
        op_ready = 1'b0;
        issue(32'h00000693, 32'h400, 4'd8, w);  // ADDI x13
        in_valid = 1'b1;
        instruction = 32'h00000713;             // ADDI x14 offered while stalled
        npc = 32'h404;
        tag_in = 4'd9;
        repeat (6) begin
            @(negedge clk);
            check("in_ready", 0, in_ready);
            check("op_valid", 1, op_valid);
            check("op_a", 32'h0, op_a);
            check("npc_out", 32'h400, npc_out);
            check("tag_out", 4'd8, tag_out);
        end
        @(posedge clk);
        #1 op_ready = 1'b1;
        issue(32'h00000713, 32'h404, 4'd9, w);
        drain();
        end_test("back-pressure");
    endtask

    task automatic store_then_load();
        int w;
        last_wb_time[0] = 0;
        issue(32'h0051A423, 32'h500, 4'd10, w); // SW x5, 8(x3)
        issue(32'h00000613, 32'h504, 4'd11, w); // ADDI x12 with no dependency
        if (w != 0)
            note_error("independent instruction refused behind a store");
        issue(32'h00002583, 32'h508, 4'd12, w); // LW x11, 0(x0)
        if (last_wb_time[0] == 0 || accept_time <= last_wb_time[0])
            note_error("load accepted before the store slot passed");
        drain();
        end_test("store then load");
    endtask

    task automatic random_stream();
        logic [31:0] r, s;
        logic [2:0] f3;
        logic [11:0] imm;
        decode_pkg::word_t instr;
        int w;
        for (int k = 0; k < 60; k++) begin
            r = lcg_next();
            s = lcg_next();
            f3 = r[22:20];
            if (r[31]) begin                    // R type with occasional SUB and SRA
                instr = {((f3 == 0 || f3 == 5) && r[23]) ? 7'h20 : 7'h00, r[19:15],
                         r[14:10], f3, 5'(1 + r[9:0] % 31), 7'h33};
            end else begin
                imm = s[11:0];
                if (f3 == 1 || f3 == 5)
                    imm[11:5] = (f3 == 5 && r[23]) ? 7'h20 : 7'h00;
                instr = {imm, r[14:10], f3, 5'(1 + r[9:0] % 31), 7'h13};
            end
            wb_val[k % 16] = lcg_next();
            issue(instr, 32'h2000 + 4 * k, decode_pkg::tag_t'(k), w);
        end
        drain();
        end_test("random stream");
    endtask

    initial begin
        in_valid = 1'b0;
        instruction = '0;
        npc = '0;
        tag_in = '0;
        op_ready = 1'b1;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
            last_wb_time[i] = 0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            pipe_val[i] = '0;
            pipe_dest[i] = -1;
        end
        for (int i = 0; i < 16; i++)
            wb_val[i] = '0;
        @(negedge clk);
        check("in_ready", 0, in_ready);         // Fetch refused while reset is held
        @(posedge reset);
        @(posedge clk);
        #1;
        reset_values();
        decode_table();
        read_after_write();
        back_pressure();
        store_then_load();
        random_stream();
        if (decode_stage_i.props_i.fail_count != 0)
            note_error("a bound assertion failed during the run");
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Watchdog sized by the instruction count
    initial begin
        #((40 * N_INSTR + 200) * CYCLE);
        $display("Watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
logic/decode_pkg.sv
logic/instr_decoder.sv
logic/register_bank.sv
logic/write_lock_queue.sv
logic/issue_control.sv
logic/decode_stage.sv
sim/tb_clock.sv
sim/decode_stage_props.sv
sim/decode_stage_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - logic/decode_pkg.sv
  - logic/instr_decoder.sv
  - logic/register_bank.sv
  - logic/write_lock_queue.sv
  - logic/issue_control.sv
  - logic/decode_stage.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/decode_stage_props.sv
      - sim/decode_stage_tb.sv
